/* hw/simd_alu_macros.svh */
// SIMD ALU constants
// Word geometry, lane saturation limits and shift field width

`ifndef SIMD_ALU_MACROS_SVH
`define SIMD_ALU_MACROS_SVH

// Word and byte slice geometry
`define SIMD_XLEN    32
`define SIMD_BYTE    8
`define SIMD_NBYTES  4

// Signed saturation limits
`define SIMD_S8_MAX  8'h7f
`define SIMD_S8_MIN  8'h80
`define SIMD_S16_MAX 16'h7fff
`define SIMD_S16_MIN 16'h8000

// Unsigned add limits, all ones
`define SIMD_U8_MAX  8'hff
`define SIMD_U16_MAX 16'hffff

`define SIMD_SHAMT_W 4

`endif

/* hw/simd_alu_pkg.sv */
// SIMD ALU package
// Operation and lane width encodings, data types, request/response
// bundles and the handshake states

`include "simd_alu_macros.svh"

package simd_alu_pkg;

  // Data word, one flag per byte slice, shift amount
  typedef logic [`SIMD_XLEN-1:0]    word_t;
  typedef logic [`SIMD_NBYTES-1:0]  byte_mask_t;
  typedef logic [`SIMD_SHAMT_W-1:0] shamt_t;

  typedef enum logic {
    W8,
    W16
  } lane_width_e;

  typedef enum logic [4:0] {
    // Wrapping
    ADD, SUB,
    // Halving, signed then unsigned
    RADD, URADD, RSUB, URSUB,
    // Saturating
    KADD, UKADD, KSUB, UKSUB,
    // Compares and min/max
    CMPEQ, SCMPLT, UCMPLT, SCMPLE, UCMPLE,
    SMIN, SMAX, UMIN, UMAX,
    // Lane shifts
    SRA, SRL, SLL
  } simd_op_e;

  typedef struct packed {
    simd_op_e    op;
    lane_width_e width;
    word_t       operand_a;
    word_t       operand_b;
  } simd_req_t;

  typedef struct packed {
    word_t result;
    logic  ov;
  } simd_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    ACK
  } hs_state_e;

endpackage

/* hw/simd_lane_adder.sv */
// SIMD lane adder
// Byte-sliced add/subtract with carry chaining inside 16-bit lanes,
// plus halving and saturating result forms with per-lane clamp flags

`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module simd_lane_adder
  import simd_alu_pkg::*;
#(
  parameter int NLANES8 = `SIMD_NBYTES
) (
  input  simd_op_e    op_i,
  input  lane_width_e width_i,
  input  word_t       operand_a_i,
  input  word_t       operand_b_i,
  output word_t       sum_o,
  output byte_mask_t  carry_o,
  output word_t       arith_result_o,
  output byte_mask_t  arith_ov_o
);

  localparam int BW = `SIMD_BYTE;

  // 16-bit limit patterns, 8-bit limits replicated in both halves
  localparam logic [2*BW-1:0] LIM_S8_MAX  = {2{`SIMD_S8_MAX}};
  localparam logic [2*BW-1:0] LIM_S8_MIN  = {2{`SIMD_S8_MIN}};
  localparam logic [2*BW-1:0] LIM_U8_MAX  = {2{`SIMD_U8_MAX}};
  localparam logic [2*BW-1:0] LIM_S16_MAX = `SIMD_S16_MAX;
  localparam logic [2*BW-1:0] LIM_S16_MIN = `SIMD_S16_MIN;
  localparam logic [2*BW-1:0] LIM_U16_MAX = `SIMD_U16_MAX;

  // Op decode, compares and min/max run as subtracts
  logic is_sub, is_unsigned, is_half, is_sat;

  assign is_sub      = op_i inside {SUB, RSUB, URSUB, KSUB, UKSUB, CMPEQ, SCMPLT, UCMPLT,
                                    SCMPLE, UCMPLE, SMIN, SMAX, UMIN, UMAX};
  assign is_unsigned = op_i inside {URADD, URSUB, UKADD, UKSUB};
  assign is_half     = op_i inside {RADD, URADD, RSUB, URSUB};
  assign is_sat      = op_i inside {KADD, UKADD, KSUB, UKSUB};

  //////////////////////////////////////////////////
  // Byte slices and carry chain
  //////////////////////////////////////////////////
  logic [NLANES8-1:0]         lane_low, lane_top, byte_cout;
  logic [NLANES8-1:0][BW-1:0] b_in;
  logic [NLANES8-1:0][BW:0]   byte_sum;
  word_t                      sum_w;

  always_comb begin
    for (int b = 0; b < NLANES8; b++) begin
      lane_low[b] = (width_i == W8) || (b % 2 == 0);
      lane_top[b] = (width_i == W8) || (b % 2 == 1);
      b_in[b]     = operand_b_i[BW*b +: BW] ^ {BW{is_sub}};
    end
  end

  for (genvar b = 0; b < NLANES8; b++) begin : gen_byte
    logic carry_in;

    // Lane low bytes take the subtract carry, others chain
    if (b == 0) begin : gen_first
      assign carry_in = is_sub;
    end else begin : gen_chain
      assign carry_in = lane_low[b] ? is_sub : byte_cout[b-1];
    end

    assign byte_sum[b] = {1'b0, operand_a_i[BW*b +: BW]} + {1'b0, b_in[b]} +
                         {{BW{1'b0}}, carry_in};
    assign byte_cout[b]        = byte_sum[b][BW];
    assign sum_w[BW*b +: BW]   = byte_sum[b][BW-1:0];
  end

  //////////////////////////////////////////////////
  // Wide lane result and overflow
  //////////////////////////////////////////////////
  // top_bit is bit n of the n+1 bit lane result, only meaningful in top bytes
  logic [NLANES8-1:0] top_bit, lane_ov;

  always_comb begin
    for (int b = 0; b < NLANES8; b++) begin
      if (is_unsigned) begin
        // Carry for add, borrow for subtract
        top_bit[b] = byte_cout[b] ^ is_sub;
        lane_ov[b] = top_bit[b];
      end else begin
        top_bit[b] = operand_a_i[BW*b+BW-1] ^ b_in[b][BW-1] ^ byte_cout[b];
        lane_ov[b] = top_bit[b] ^ sum_w[BW*b+BW-1];
      end
    end
  end

  // Halving: wide lane result shifted right by one
  word_t half_w;

  always_comb begin
    half_w = sum_w >> 1;
    for (int b = 0; b < NLANES8; b++) begin
      if (lane_top[b]) begin
        half_w[BW*b+BW-1] = top_bit[b];
      end
    end
  end

  // Saturation, each byte follows the clamp of its lane top byte
  word_t sat_w;

  always_comb begin
    int t;
    logic [2*BW-1:0] lim;
    for (int b = 0; b < NLANES8; b++) begin
      t = lane_top[b] ? b : b + 1;
      if (is_unsigned) begin
        lim = is_sub ? '0 : ((width_i == W8) ? LIM_U8_MAX : LIM_U16_MAX);
      end else if (top_bit[t]) begin
        lim = (width_i == W8) ? LIM_S8_MIN : LIM_S16_MIN;
      end else begin
        lim = (width_i == W8) ? LIM_S8_MAX : LIM_S16_MAX;
      end
      if (lane_ov[t]) begin
        sat_w[BW*b +: BW] = (b % 2 == 1) ? lim[2*BW-1:BW] : lim[BW-1:0];
      end else begin
        sat_w[BW*b +: BW] = sum_w[BW*b +: BW];
      end
    end
  end

  assign sum_o          = sum_w;
  assign carry_o        = byte_cout;
  assign arith_ov_o     = lane_top & lane_ov & {NLANES8{is_sat}};
  assign arith_result_o = is_half ? half_w : (is_sat ? sat_w : sum_w);

endmodule

/* hw/simd_lane_compare.sv */
// SIMD lane compare
// Lane equality and less-than from the adder difference, compare
// masks and min/max lane selection

`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module simd_lane_compare
  import simd_alu_pkg::*;
(
  input  simd_op_e    op_i,
  input  lane_width_e width_i,
  input  word_t       operand_a_i,
  input  word_t       operand_b_i,
  input  word_t       sum_i,
  input  byte_mask_t  carry_i,
  output word_t       cmp_result_o
);

  localparam int BW = `SIMD_BYTE;
  localparam int NB = `SIMD_NBYTES;

  logic is_signed, is_minmax;

  assign is_signed = op_i inside {SCMPLT, SCMPLE, SMIN, SMAX};
  assign is_minmax = op_i inside {SMIN, SMAX, UMIN, UMAX};

  //////////////////////////////////////////////////
  // Per-lane equal and less-than
  //////////////////////////////////////////////////
  byte_mask_t byte_zero, lane_eq, lane_lt;

  always_comb begin
    int lo;
    int hi;
    logic a_s;
    logic b_s;
    for (int b = 0; b < NB; b++) begin
      byte_zero[b] = (sum_i[BW*b +: BW] == '0);
    end
    for (int b = 0; b < NB; b++) begin
      lo = (width_i == W8) ? b : (b / 2) * 2;
      hi = (width_i == W8) ? b : (b / 2) * 2 + 1;
      lane_eq[b] = byte_zero[lo] & byte_zero[hi];
      a_s = operand_a_i[BW*hi+BW-1];
      b_s = operand_b_i[BW*hi+BW-1];
      // Same signs: the wide difference sign is the inverted carry
      if (a_s == b_s) begin
        lane_lt[b] = ~carry_i[hi];
      end else begin
        lane_lt[b] = is_signed ? a_s : b_s;
      end
    end
  end

  // Compare mask, also picks A for min/max
  byte_mask_t mask;

  always_comb begin
    unique case (op_i)
      CMPEQ:                      mask = lane_eq;
      SCMPLT, UCMPLT, SMIN, UMIN: mask = lane_lt;
      SCMPLE, UCMPLE:             mask = lane_lt | lane_eq;
      SMAX, UMAX:                 mask = ~lane_lt;
      default:                    mask = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Result forming
  //////////////////////////////////////////////////
  always_comb begin
    for (int b = 0; b < NB; b++) begin
      if (is_minmax) begin
        cmp_result_o[BW*b +: BW] = mask[b] ? operand_a_i[BW*b +: BW]
                                           : operand_b_i[BW*b +: BW];
      end else begin
        cmp_result_o[BW*b +: BW] = {BW{mask[b]}};
      end
    end
  end

endmodule

/* hw/simd_lane_shifter.sv */
// SIMD lane shifter
// Word-wide right shift with lane masking and sign fill, left shifts
// done by bit reversal around the same shifter

`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module simd_lane_shifter
  import simd_alu_pkg::*;
(
  input  simd_op_e    op_i,
  input  lane_width_e width_i,
  input  word_t       operand_a_i,
  input  shamt_t      shamt_i,
  output word_t       shift_result_o
);

  localparam int XLEN = `SIMD_XLEN;
  localparam int BW   = `SIMD_BYTE;

  function automatic word_t reverse_bits(input word_t w);
    word_t r;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = w[XLEN-1-i];
    end
    return r;
  endfunction

  logic   is_left, is_arith;
  shamt_t amt;
  word_t  shift_in, shift_raw, lane_mask, sign_fill, shift_pre;

  assign is_left  = (op_i == SLL);
  assign is_arith = (op_i == SRA);

  // Byte lanes only use three amount bits
  assign amt = (width_i == W8) ? {1'b0, shamt_i[2:0]} : shamt_i;

  assign shift_in  = is_left ? reverse_bits(operand_a_i) : operand_a_i;
  assign shift_raw = shift_in >> amt;

  //////////////////////////////////////////////////
  // Lane masks
  //////////////////////////////////////////////////
  logic [2*BW-1:0] therm;

  always_comb begin
    // Top amt bits of each lane came from the lane above
    for (int i = 0; i < 2 * BW; i++) begin
      therm[2*BW-1-i] = (i >= int'(amt));
    end
    if (width_i == W8) begin
      lane_mask = {(XLEN/BW){therm[2*BW-1 -: BW]}};
    end else begin
      lane_mask = {(XLEN/(2*BW)){therm}};
    end
  end

  // Sign fill for arithmetic shifts
  always_comb begin
    logic s;
    for (int b = 0; b < XLEN / BW; b++) begin
      s = (width_i == W8) ? operand_a_i[BW*b+BW-1] : operand_a_i[2*BW*(b/2)+2*BW-1];
      sign_fill[BW*b +: BW] = {BW{is_arith & s}} & ~lane_mask[BW*b +: BW];
    end
  end

  assign shift_pre      = (shift_raw & lane_mask) | sign_fill;
  assign shift_result_o = is_left ? reverse_bits(shift_pre) : shift_pre;

endmodule

/* hw/simd_alu_handshake.sv */
// SIMD ALU handshake stage
// Four-phase req/ack FSM that captures one request, selects the
// datapath result by operation group and holds the response

`timescale 1ns/10ps

module simd_alu_handshake
  import simd_alu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       req_i,
  input  simd_req_t  req_data_i,
  input  word_t      arith_result_i,
  input  byte_mask_t arith_ov_i,
  input  word_t      cmp_result_i,
  input  word_t      shift_result_i,
  output simd_req_t  cur_req_o,
  output logic       ack_o,
  output simd_rsp_t  rsp_o
);

  hs_state_e state_q, state_d;
  simd_req_t req_q;
  simd_rsp_t rsp_q, rsp_d;
  logic      capture, load;

  //////////////////////////////////////////////////
  // Handshake FSM
  //////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          state_d = CALC;
        end
      end
      // Datapath settles during this cycle
      CALC: state_d = ACK;
      ACK: begin
        if (!req_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign capture = (state_q == IDLE) && req_i;
  assign load    = (state_q == CALC);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      req_q <= req_data_i;
    end
  end

  //////////////////////////////////////////////////
  // Result select and response register
  //////////////////////////////////////////////////
  always_comb begin
    rsp_d.ov = 1'b0;
    unique case (req_q.op)
      ADD, SUB, RADD, URADD, RSUB, URSUB: rsp_d.result = arith_result_i;
      KADD, UKADD, KSUB, UKSUB: begin
        rsp_d.result = arith_result_i;
        rsp_d.ov     = |arith_ov_i;
      end
      SRA, SRL, SLL: rsp_d.result = shift_result_i;
      default:       rsp_d.result = cmp_result_i;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_q <= '0;
    end else if (load) begin
      rsp_q <= rsp_d;
    end
  end

  assign cur_req_o = req_q;
  assign ack_o     = (state_q == ACK);
  assign rsp_o     = rsp_q;

endmodule

/* hw/simd_alu_top.sv */
// SIMD ALU top level
// Handshake stage feeding the lane adder, compare and shifter

`timescale 1ns/10ps
`include "simd_alu_macros.svh"

module simd_alu_top
  import simd_alu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_i,
  input  simd_req_t req_data_i,
  output logic      ack_o,
  output simd_rsp_t rsp_o
);

  simd_req_t  cur_req;
  word_t      sum, arith_result, cmp_result, shift_result;
  byte_mask_t carry, arith_ov;

  simd_alu_handshake u_handshake (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (req_i),
    .req_data_i     (req_data_i),
    .arith_result_i (arith_result),
    .arith_ov_i     (arith_ov),
    .cmp_result_i   (cmp_result),
    .shift_result_i (shift_result),
    .cur_req_o      (cur_req),
    .ack_o          (ack_o),
    .rsp_o          (rsp_o)
  );

  simd_lane_adder #(
    .NLANES8 (`SIMD_NBYTES)
  ) u_adder (
    .op_i           (cur_req.op),
    .width_i        (cur_req.width),
    .operand_a_i    (cur_req.operand_a),
    .operand_b_i    (cur_req.operand_b),
    .sum_o          (sum),
    .carry_o        (carry),
    .arith_result_o (arith_result),
    .arith_ov_o     (arith_ov)
  );

  // Compare reuses the adder difference
  simd_lane_compare u_compare (
    .op_i         (cur_req.op),
    .width_i      (cur_req.width),
    .operand_a_i  (cur_req.operand_a),
    .operand_b_i  (cur_req.operand_b),
    .sum_i        (sum),
    .carry_i      (carry),
    .cmp_result_o (cmp_result)
  );

  simd_lane_shifter u_shifter (
    .op_i           (cur_req.op),
    .width_i        (cur_req.width),
    .operand_a_i    (cur_req.operand_a),
    .shamt_i        (cur_req.operand_b[`SIMD_SHAMT_W-1:0]),
    .shift_result_o (shift_result)
  );

endmodule

/* testbench/tb_simd_alu_ref.svh */
// SIMD ALU reference model
// Lane by lane expected result and overflow for one request

`ifndef TB_SIMD_ALU_REF_SVH
`define TB_SIMD_ALU_REF_SVH

function automatic simd_rsp_t simd_ref(input simd_req_t req);
  simd_rsp_t rsp;
  int        lw;
  int        nl;
  int        amt;
  longint    ua, ub, sa, sb, r;
  longint    umax, smax, smin;
  rsp  = '0;
  lw   = (req.width == W8) ? 8 : 16;
  nl   = 32 / lw;
  umax = (longint'(1) << lw) - 1;
  smax = (longint'(1) << (lw - 1)) - 1;
  smin = -(smax + 1);
  // Amount field is 3 bits for byte lanes, 4 bits for halfword lanes
  amt  = int'(req.operand_b[3:0]) & ((req.width == W8) ? 7 : 15);
  for (int i = 0; i < nl; i++) begin
    ua = (req.operand_a >> (lw * i)) & umax;
    ub = (req.operand_b >> (lw * i)) & umax;
    sa = (ua > smax) ? ua - (umax + 1) : ua;
    sb = (ub > smax) ? ub - (umax + 1) : ub;
    unique case (req.op)
      ADD:    r = ua + ub;
      SUB:    r = ua - ub;
      RADD:   r = (sa + sb) >>> 1;
      URADD:  r = (ua + ub) >>> 1;
      RSUB:   r = (sa - sb) >>> 1;
      URSUB:  r = (ua - ub) >>> 1;
      KADD, KSUB: begin
        r = (req.op == KADD) ? sa + sb : sa - sb;
        if (r > smax) begin
          r = smax;
          rsp.ov = 1'b1;
        end else if (r < smin) begin
          r = smin;
          rsp.ov = 1'b1;
        end
      end
      UKADD: begin
        r = ua + ub;
        if (r > umax) begin
          r = umax;
          rsp.ov = 1'b1;
        end
      end
      UKSUB: begin
        r = ua - ub;
        if (r < 0) begin
          r = 0;
          rsp.ov = 1'b1;
        end
      end
      CMPEQ:  r = (ua == ub) ? umax : 0;
      SCMPLT: r = (sa < sb) ? umax : 0;
      UCMPLT: r = (ua < ub) ? umax : 0;
      SCMPLE: r = (sa <= sb) ? umax : 0;
      UCMPLE: r = (ua <= ub) ? umax : 0;
      SMIN:   r = (sa <= sb) ? ua : ub;
      SMAX:   r = (sa >= sb) ? ua : ub;
      UMIN:   r = (ua <= ub) ? ua : ub;
      UMAX:   r = (ua >= ub) ? ua : ub;
      SRA:    r = sa >>> amt;
      SRL:    r = ua >> amt;
      SLL:    r = ua << amt;
      default: r = 0;
    endcase
    rsp.result = rsp.result | (word_t'(r & umax) << (lw * i));
  end
  return rsp;
endfunction

`endif

/* testbench/tb_simd_alu.sv */
// SIMD ALU testbench
// Directed and random requests over the four-phase handshake,
// responses compared against the reference model

`timescale 1ns/10ps

module tb_simd_alu
  import simd_alu_pkg::*;
();

  `include "tb_simd_alu_ref.svh"

  localparam int NUM_PAIRS    = 7;
  localparam int NUM_DIRECTED = 22 * 2 * NUM_PAIRS + 3 * (8 + 16);
  localparam int NUM_RANDOM   = 400;
  localparam int NUM_TXN      = NUM_DIRECTED + NUM_RANDOM;
  localparam int CYCLE_LIMIT  = NUM_TXN * 8 + 100;

  logic      clk_i = 1'b0;
  logic      rst_n_i;
  logic      req_i;
  simd_req_t req_data_i;
  logic      ack_o;
  simd_rsp_t rsp_o;

  int        seed = 40658;
  int        errors = 0;
  int        checked = 0;
  int        cycles = 0;
  simd_req_t pending[$];

  // Carry boundaries, saturation limits, equal and mixed-sign lanes
  word_t pair_a[NUM_PAIRS] = '{32'h7f7f_7fff, 32'h8080_8000, 32'hffff_ffff, 32'h00ff_00ff,
                               32'h1234_8765, 32'h8001_7fff, 32'h0000_0100};
  word_t pair_b[NUM_PAIRS] = '{32'h0101_0001, 32'h7f7f_0001, 32'h0101_0001, 32'h0001_0001,
                               32'h1234_8765, 32'h7fff_8001, 32'h0001_0101};
  simd_op_e shift_ops[3] = '{SRA, SRL, SLL};

  simd_alu_top uut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .ack_o      (ack_o),
    .rsp_o      (rsp_o)
  );

  always #20 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (act !== exp) begin
      $display("error: %s expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Requester side of the four-phase handshake
  //////////////////////////////////////////////////
  task automatic run_request(input simd_req_t r);
    int hold;
    int edges;
    hold = {$random(seed)} % 4;
    @(posedge clk_i);
    req_i      <= 1'b1;
    req_data_i <= r;
    pending.push_back(r);
    @(negedge clk_i);
    edges = 0;
    while (!ack_o) begin
      @(negedge clk_i);
      edges++;
    end
    check_value("ack_o latency", 2, edges);
    repeat (hold) begin
      @(negedge clk_i);
      check_value("ack_o", 1, ack_o);
    end
    @(posedge clk_i);
    req_i <= 1'b0;
    // Still high until the unit samples req_i low
    @(negedge clk_i);
    check_value("ack_o", 1, ack_o);
    @(negedge clk_i);
    check_value("ack_o", 0, ack_o);
  endtask

  // Compare process, one check per ack rise
  initial begin : compare
    simd_rsp_t exp;
    simd_rsp_t held;
    simd_req_t r;
    logic      ack_prev;
    ack_prev = 1'b0;
    held     = '0;
    forever begin
      @(negedge clk_i);
      if (ack_o && !ack_prev) begin
        if (pending.size() == 0) begin
          $display("ack_o rose while no request was outstanding");
          errors++;
        end else begin
          r    = pending.pop_front();
          exp  = simd_ref(r);
          check_value("rsp_o.result", exp.result, rsp_o.result);
          check_value("rsp_o.ov", exp.ov, rsp_o.ov);
          held = exp;
          checked++;
        end
      end else if (ack_o) begin
        check_value("rsp_o held", held, rsp_o);
      end
      ack_prev = ack_o;
    end
  end

  initial begin : watchdog
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Responses checked %0d of %0d, errors %0d", checked, NUM_TXN, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial begin : stimulus
    simd_req_t r;
    rst_n_i    = 1'b0;
    req_i      = 1'b0;
    req_data_i = '0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_value("ack_o", 0, ack_o);
    check_value("rsp_o", 0, rsp_o);

    // Every operation on the boundary pairs in both widths
    for (int w = 0; w < 2; w++) begin
      for (int o = 0; o < 22; o++) begin
        for (int p = 0; p < NUM_PAIRS; p++) begin
          r.op        = simd_op_e'(o);
          r.width     = lane_width_e'(w);
          r.operand_a = pair_a[p];
          r.operand_b = pair_b[p];
          run_request(r);
        end
      end
    end

    // Shift amount sweep, upper B bits are noise
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < 3; s++) begin
        for (int amt = 0; amt < ((w == 0) ? 8 : 16); amt++) begin
          r.op        = shift_ops[s];
          r.width     = lane_width_e'(w);
          r.operand_a = $random(seed);
          r.operand_b = ($random(seed) & 32'hffff_fff0) | amt;
          run_request(r);
        end
      end
    end

    repeat (NUM_RANDOM) begin
      r.op        = simd_op_e'({$random(seed)} % 22);
      r.width     = lane_width_e'({$random(seed)} % 2);
      r.operand_a = $random(seed);
      r.operand_b = $random(seed);
      run_request(r);
    end

    repeat (4) @(negedge clk_i);
    if (pending.size() != 0) begin
      $display("%0d requests never received an ack", pending.size());
      errors++;
    end
    $display("Responses checked %0d of %0d, errors %0d", checked, NUM_TXN, errors);
    if (errors == 0 && checked == NUM_TXN) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+hw
+incdir+testbench
hw/simd_alu_pkg.sv
hw/simd_lane_adder.sv
hw/simd_lane_compare.sv
hw/simd_lane_shifter.sv
hw/simd_alu_handshake.sv
hw/simd_alu_top.sv
testbench/tb_simd_alu.sv

/* Bender.yml */
package:
  name: simd_alu

sources:
  - include_dirs:
      - hw
    files:
      - hw/simd_alu_pkg.sv
      - hw/simd_lane_adder.sv
      - hw/simd_lane_compare.sv
      - hw/simd_lane_shifter.sv
      - hw/simd_alu_handshake.sv
      - hw/simd_alu_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_simd_alu.sv
